// ==== ethgen_pkg.sv ====
// shared types for the frame generator; CNT_W must stay 16, it matches the 16 bit descriptor fields
`default_nettype none

package ethgen_pkg;

   // ----------------------------------------------------------------------
   // constants
   // ----------------------------------------------------------------------
   localparam int CNT_W = 16;                      // counters, saturating

   localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
   localparam logic [7:0] SFD_BYTE      = 8'hD5;
   localparam logic [7:0] VLAN_TPID_HI  = 8'h81;   // 802.1Q tpid 0x8100
   localparam logic [7:0] VLAN_TPID_LO  = 8'h00;

   localparam logic [CNT_W-1:0] MIN_FRAME_BYTES = 16'd60;  // dst through pad, crc excluded
   localparam logic [CNT_W-1:0] ADDR_BYTES      = 16'd6;

   localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7;  // ieee 802.3
   localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

   // ----------------------------------------------------------------------
   // frame fields, order matters: DST..PAD is the crc range
   // ----------------------------------------------------------------------
   typedef enum logic [3:0] {
      FLD_IDLE     = 4'd0,
      FLD_PREAMBLE = 4'd1,
      FLD_SFD      = 4'd2,
      FLD_DST      = 4'd3,
      FLD_SRC      = 4'd4,
      FLD_TAG      = 4'd5,
      FLD_LENTYPE  = 4'd6,
      FLD_DATA     = 4'd7,
      FLD_PAD      = 4'd8,
      FLD_CRC      = 4'd9,
      FLD_IPG      = 4'd10
   } field_e;

   // frame descriptor, latched on an accepted start
   typedef struct packed {
      logic [47:0] dst;            // sent lsb first
      logic [47:0] src;            // sent lsb first
      logic [3:0]  preamble_len;   // 0 behaves as 1
      logic        vlan_en;        // insert one 802.1Q tag
      logic [15:0] vlan_ctl;       // tci, high byte first
      logic [15:0] len;            // payload bytes
      logic [15:0] frmtype;        // non-zero replaces len on the wire
      logic [7:0]  cnt_start;      // payload byte 0
      logic [7:0]  cnt_step;       // payload byte 1, also the step
      logic        pad_en;         // pad to MIN_FRAME_BYTES
      logic [15:0] ipg_len;        // idle cycles after crc
   } frame_desc_t;

   // per byte control word from the sequencer
   typedef struct packed {
      field_e           field;
      logic [CNT_W-1:0] count;     // byte index inside field
      logic             sop;       // first preamble byte
      logic             eop;       // last crc byte
   } gen_ctrl_t;

endpackage

`default_nettype wire

// ==== frame_sequencer.sv ====
// one frame per accepted start; desc_i must be the latched descriptor, stable until idle again
`default_nettype none
`timescale 1ns/1ps

module frame_sequencer
(
   input  logic                    rx_clk,
   input  logic                    reset,
   input  logic                    start_i,   // already qualified by done
   input  ethgen_pkg::frame_desc_t desc_i,
   output ethgen_pkg::gen_ctrl_t   ctrl_o,
   output logic                    idle_o
);

   ethgen_pkg::gen_ctrl_t ctrl_q;
   ethgen_pkg::gen_ctrl_t nxt;

   logic [ethgen_pkg::CNT_W-1:0] pos_q;      // index from first dst byte
   logic [ethgen_pkg::CNT_W-1:0] pos_nxt;
   logic [ethgen_pkg::CNT_W-1:0] cnt_inc;
   logic [ethgen_pkg::CNT_W-1:0] pos_inc;
   logic [ethgen_pkg::CNT_W-1:0] pre_last;   // index of last preamble byte
   logic                         pad_need;

   // ----------------------------------------------------------------------
   // helpers
   // ----------------------------------------------------------------------
   assign cnt_inc = (ctrl_q.count == '1) ? ctrl_q.count : ctrl_q.count + 1'b1;  // saturate
   assign pos_inc = (pos_q == '1) ? pos_q : pos_q + 1'b1;

   always_comb
   begin
      pre_last = '0;                         // a zero length still sends one byte
      if (desc_i.preamble_len > 4'd1)
         pre_last = {{(ethgen_pkg::CNT_W-4){1'b0}}, desc_i.preamble_len - 4'd1};
   end

   // more bytes needed before reaching the minimum size
   assign pad_need = desc_i.pad_en && (pos_q < ethgen_pkg::MIN_FRAME_BYTES - 1'b1);

   // ----------------------------------------------------------------------
   // next field and index
   // ----------------------------------------------------------------------
   always_comb
   begin
      nxt       = ctrl_q;
      nxt.sop   = 1'b0;
      nxt.eop   = 1'b0;
      nxt.count = cnt_inc;
      pos_nxt   = pos_inc;
      case (ctrl_q.field)
         ethgen_pkg::FLD_IDLE:
         begin
            nxt.count = '0;
            if (start_i)
            begin
               nxt.field = ethgen_pkg::FLD_PREAMBLE;
               nxt.sop   = 1'b1;             // rides with first preamble byte
            end
         end
         ethgen_pkg::FLD_PREAMBLE:
         begin
            if (ctrl_q.count >= pre_last)
            begin
               nxt.field = ethgen_pkg::FLD_SFD;
               nxt.count = '0;
            end
         end
         ethgen_pkg::FLD_SFD:
         begin
            nxt.field = ethgen_pkg::FLD_DST;
            nxt.count = '0;
            pos_nxt   = '0;                  // position starts at dst byte 0
         end
         ethgen_pkg::FLD_DST:
         begin
            if (ctrl_q.count == ethgen_pkg::ADDR_BYTES - 1'b1)
            begin
               nxt.field = ethgen_pkg::FLD_SRC;
               nxt.count = '0;
            end
         end
         ethgen_pkg::FLD_SRC:
         begin
            if (ctrl_q.count == ethgen_pkg::ADDR_BYTES - 1'b1)
            begin
               nxt.field = desc_i.vlan_en ? ethgen_pkg::FLD_TAG : ethgen_pkg::FLD_LENTYPE;
               nxt.count = '0;
            end
         end
         ethgen_pkg::FLD_TAG:
         begin
            if (ctrl_q.count == 16'd3)       // tpid hi/lo, tci hi/lo
            begin
               nxt.field = ethgen_pkg::FLD_LENTYPE;
               nxt.count = '0;
            end
         end
         ethgen_pkg::FLD_LENTYPE:
         begin
            if (ctrl_q.count == 16'd1)
            begin
               nxt.count = '0;
               if (desc_i.len != 16'd0)
                  nxt.field = ethgen_pkg::FLD_DATA;
               else if (pad_need)
                  nxt.field = ethgen_pkg::FLD_PAD;   // empty payload
               else
                  nxt.field = ethgen_pkg::FLD_CRC;
            end
         end
         ethgen_pkg::FLD_DATA:
         begin
            if (ctrl_q.count >= desc_i.len - 16'd1)
            begin
               nxt.field = pad_need ? ethgen_pkg::FLD_PAD : ethgen_pkg::FLD_CRC;
               nxt.count = '0;
            end
         end
         ethgen_pkg::FLD_PAD:
         begin
            if (!pad_need)                   // this byte is position 59
            begin
               nxt.field = ethgen_pkg::FLD_CRC;
               nxt.count = '0;
            end
         end
         ethgen_pkg::FLD_CRC:
         begin
            if (ctrl_q.count == 16'd2)
               nxt.eop = 1'b1;               // next one is the last crc byte
            if (ctrl_q.count == 16'd3)
            begin
               nxt.field = (desc_i.ipg_len != 16'd0) ? ethgen_pkg::FLD_IPG
                                                     : ethgen_pkg::FLD_IDLE;
               nxt.count = '0;
            end
         end
         ethgen_pkg::FLD_IPG:
         begin
            if (ctrl_q.count >= desc_i.ipg_len - 16'd1)
            begin
               nxt.field = ethgen_pkg::FLD_IDLE;
               nxt.count = '0;
            end
         end
         default:
         begin
            nxt.field = ethgen_pkg::FLD_IDLE;   // stray encoding, recover
            nxt.count = '0;
         end
      endcase
   end

   always_ff @(posedge rx_clk or posedge reset)
   begin
      if (reset)
      begin
         ctrl_q <= '{field: ethgen_pkg::FLD_IDLE, count: '0, sop: 1'b0, eop: 1'b0};
         pos_q  <= '0;
      end
      else
      begin
         ctrl_q <= nxt;
         pos_q  <= pos_nxt;
      end
   end

   assign ctrl_o = ctrl_q;
   assign idle_o = (ctrl_q.field == ethgen_pkg::FLD_IDLE);

endmodule

`default_nettype wire

// ==== header_byte_mux.sv ====
// header byte lookup, combinational; output is don't-care outside the header fields
`default_nettype none
`timescale 1ns/1ps

module header_byte_mux
(
   input  ethgen_pkg::frame_desc_t desc_i,
   input  ethgen_pkg::gen_ctrl_t   ctrl_i,
   output logic [7:0]              hdr_byte_o
);

   logic [15:0] lentype;     // word sent in the length/type slot

   // address byte, lsb first on the wire
   function automatic logic [7:0] addr_byte(input logic [47:0] addr, input logic [2:0] idx);
      logic [7:0] b;
      case (idx)
         3'd0:    b = addr[7:0];
         3'd1:    b = addr[15:8];
         3'd2:    b = addr[23:16];
         3'd3:    b = addr[31:24];
         3'd4:    b = addr[39:32];
         3'd5:    b = addr[47:40];
         default: b = 8'h00;
      endcase
      return b;
   endfunction

   assign lentype = (desc_i.frmtype != 16'd0) ? desc_i.frmtype : desc_i.len;  // type wins

   always_comb
   begin
      case (ctrl_i.field)
         ethgen_pkg::FLD_PREAMBLE: hdr_byte_o = ethgen_pkg::PREAMBLE_BYTE;
         ethgen_pkg::FLD_SFD:      hdr_byte_o = ethgen_pkg::SFD_BYTE;
         ethgen_pkg::FLD_DST:      hdr_byte_o = addr_byte(desc_i.dst, ctrl_i.count[2:0]);
         ethgen_pkg::FLD_SRC:      hdr_byte_o = addr_byte(desc_i.src, ctrl_i.count[2:0]);
         ethgen_pkg::FLD_TAG:
         begin
            case (ctrl_i.count[1:0])
               2'd0:    hdr_byte_o = ethgen_pkg::VLAN_TPID_HI;
               2'd1:    hdr_byte_o = ethgen_pkg::VLAN_TPID_LO;
               2'd2:    hdr_byte_o = desc_i.vlan_ctl[15:8];  // tci high first
               default: hdr_byte_o = desc_i.vlan_ctl[7:0];
            endcase
         end
         ethgen_pkg::FLD_LENTYPE:
            hdr_byte_o = ctrl_i.count[0] ? lentype[7:0] : lentype[15:8];  // network order
         default:
            hdr_byte_o = 8'h00;      // data, pad, crc come from elsewhere
      endcase
   end

endmodule

`default_nettype wire

// ==== payload_pattern.sv ====
// counting payload; byte values wrap modulo 256, no error pattern
`default_nettype none
`timescale 1ns/1ps

module payload_pattern
(
   input  logic                    rx_clk,
   input  logic                    reset,
   input  ethgen_pkg::frame_desc_t desc_i,
   input  ethgen_pkg::gen_ctrl_t   ctrl_i,
   output logic [7:0]              pay_byte_o
);

   logic [7:0] data_q;       // next counting value
   logic       in_data;

   assign in_data = (ctrl_i.field == ethgen_pkg::FLD_DATA);

   // start value at byte 0, step from byte 2 on
   always_ff @(posedge rx_clk or posedge reset)
   begin
      if (reset)
         data_q <= 8'h00;
      else if (in_data)
      begin
         if (ctrl_i.count == 16'd0)
            data_q <= desc_i.cnt_start;
         else if (ctrl_i.count >= 16'd2)
            data_q <= data_q + desc_i.cnt_step;  // wraps
      end
   end

   // byte 0 start, byte 1 step, then the counter
   always_comb
   begin
      if (ctrl_i.count == 16'd0)
         pay_byte_o = desc_i.cnt_start;
      else if (ctrl_i.count == 16'd1)
         pay_byte_o = desc_i.cnt_step;
      else
         pay_byte_o = data_q;
   end

endmodule

`default_nettype wire

// ==== crc32_gen.sv ====
// ethernet fcs over dst..pad; byte_i must be the byte on the line for the same ctrl
`default_nettype none
`timescale 1ns/1ps

module crc32_gen
(
   input  logic                  rx_clk,
   input  logic                  reset,
   input  ethgen_pkg::gen_ctrl_t ctrl_i,
   input  logic [7:0]            byte_i,
   output logic [7:0]            crc_byte_o
);

   logic [31:0] crc_q;
   logic [7:0]  crc_sel;     // register byte for this crc index
   logic        fold_en;

   // one byte, lsb first, msb-first shift register form
   function automatic logic [31:0] crc_fold(input logic [31:0] crc, input logic [7:0] data);
      logic [31:0] c;
      c = crc;
      for (int i = 0; i < 8; i++)
      begin
         if (data[i] ^ c[31])
            c = (c << 1) ^ ethgen_pkg::CRC_POLY;
         else
            c = c << 1;
      end
      return c;
   endfunction

   // covered range, relies on field_e ordering
   assign fold_en = (ctrl_i.field >= ethgen_pkg::FLD_DST) &&
                    (ctrl_i.field <= ethgen_pkg::FLD_PAD);

   // ----------------------------------------------------------------------
   // running register
   // ----------------------------------------------------------------------
   always_ff @(posedge rx_clk or posedge reset)
   begin
      if (reset)
         crc_q <= ethgen_pkg::CRC_INIT;
      else if (ctrl_i.field == ethgen_pkg::FLD_SFD)
         crc_q <= ethgen_pkg::CRC_INIT;         // fresh for every frame
      else if (fold_en)
         crc_q <= crc_fold(crc_q, byte_i);
   end

   // ----------------------------------------------------------------------
   // fcs bytes: index k takes register byte 3-k
   // ----------------------------------------------------------------------
   assign crc_sel = crc_q[{~ctrl_i.count[1:0], 3'b000} +: 8];

   always_comb
   begin
      for (int i = 0; i < 8; i++)
         crc_byte_o[i] = ~crc_sel[7-i];         // reversed and inverted
   end

endmodule

`default_nettype wire

// ==== gmii_rx_stage.sv ====
// gmii style output register, no rx_er and no hold delay
`default_nettype none
`timescale 1ns/1ps

module gmii_rx_stage
(
   input  logic                  rx_clk,
   input  logic                  reset,
   input  ethgen_pkg::gen_ctrl_t ctrl_i,
   input  logic [7:0]            hdr_byte_i,
   input  logic [7:0]            pay_byte_i,
   input  logic [7:0]            crc_byte_i,
   output logic [7:0]            line_byte_o,  // also feeds the crc
   output logic [7:0]            rxd_o,
   output logic                  rx_dv_o,
   output logic                  sop_o,
   output logic                  eop_o
);

   logic active;             // a frame byte this cycle

   assign active = (ctrl_i.field != ethgen_pkg::FLD_IDLE) &&
                   (ctrl_i.field != ethgen_pkg::FLD_IPG);

   // byte source by field
   always_comb
   begin
      case (ctrl_i.field)
         ethgen_pkg::FLD_DATA: line_byte_o = pay_byte_i;
         ethgen_pkg::FLD_PAD:  line_byte_o = 8'h00;
         ethgen_pkg::FLD_CRC:  line_byte_o = crc_byte_i;
         default:              line_byte_o = hdr_byte_i;  // preamble..lentype
      endcase
   end

   always_ff @(posedge rx_clk or posedge reset)
   begin
      if (reset)
      begin
         rxd_o   <= 8'h00;
         rx_dv_o <= 1'b0;
         sop_o   <= 1'b0;
         eop_o   <= 1'b0;
      end
      else
      begin
         rxd_o   <= active ? line_byte_o : 8'h00;  // quiet line between frames
         rx_dv_o <= active;
         sop_o   <= ctrl_i.sop;                    // markers straight from the sequencer
         eop_o   <= ctrl_i.eop;
      end
   end

endmodule

`default_nettype wire

// ==== ethgen_top.sv ====
// start_i is taken only while done_o is high; starts while busy are dropped
`default_nettype none
`timescale 1ns/1ps

module ethgen_top
(
   input  logic                    rx_clk,
   input  logic                    reset,
   input  logic                    start_i,
   input  ethgen_pkg::frame_desc_t desc_i,
   output logic [7:0]              rxd_o,
   output logic                    rx_dv_o,
   output logic                    sop_o,
   output logic                    eop_o,
   output logic                    done_o
);

   ethgen_pkg::frame_desc_t desc_q;     // held for the whole frame
   ethgen_pkg::gen_ctrl_t   ctrl;
   logic                    idle;
   logic                    start_ok;   // accepted start
   logic [7:0]              hdr_byte;
   logic [7:0]              pay_byte;
   logic [7:0]              crc_byte;
   logic [7:0]              line_byte;

   assign start_ok = start_i & done_o & idle;

   // ----------------------------------------------------------------------
   // descriptor latch and done flag
   // ----------------------------------------------------------------------
   always_ff @(posedge rx_clk)
   begin
      if (start_ok)
         desc_q <= desc_i;
   end

   always_ff @(posedge rx_clk or posedge reset)
   begin
      if (reset)
         done_o <= 1'b1;
      else if (start_ok)
         done_o <= 1'b0;                // busy from next edge
      else if (idle)
         done_o <= 1'b1;                // back one cycle after idle
   end

   frame_sequencer u_seq
   (
      .rx_clk  (rx_clk),
      .reset   (reset),
      .start_i (start_ok),
      .desc_i  (desc_q),
      .ctrl_o  (ctrl),
      .idle_o  (idle)
   );

   header_byte_mux u_hdr
   (
      .desc_i     (desc_q),
      .ctrl_i     (ctrl),
      .hdr_byte_o (hdr_byte)
   );

   payload_pattern u_pay
   (
      .rx_clk     (rx_clk),
      .reset      (reset),
      .desc_i     (desc_q),
      .ctrl_i     (ctrl),
      .pay_byte_o (pay_byte)
   );

   crc32_gen u_crc
   (
      .rx_clk     (rx_clk),
      .reset      (reset),
      .ctrl_i     (ctrl),
      .byte_i     (line_byte),
      .crc_byte_o (crc_byte)
   );

   gmii_rx_stage u_out
   (
      .rx_clk      (rx_clk),
      .reset       (reset),
      .ctrl_i      (ctrl),
      .hdr_byte_i  (hdr_byte),
      .pay_byte_i  (pay_byte),
      .crc_byte_i  (crc_byte),
      .line_byte_o (line_byte),
      .rxd_o       (rxd_o),
      .rx_dv_o     (rx_dv_o),
      .sop_o       (sop_o),
      .eop_o       (eop_o)
   );

endmodule

`default_nettype wire

// ==== ethgen_checker.sv ====
// framing rules on the gmii outputs, sampled on rx_clk, off during reset
`default_nettype none
`timescale 1ns/1ps

module ethgen_checker
(
   input logic       rx_clk,
   input logic       reset,
   input logic [7:0] rxd_i,
   input logic       rx_dv_i,
   input logic       sop_i,
   input logic       eop_i,
   input logic       done_i
);

   // ------------------------------------------------------------------
   // line quiet outside frames
   // ------------------------------------------------------------------
   assert property (@(posedge rx_clk) disable iff (reset) !rx_dv_i |-> rxd_i == 8'h00)
      else $error("rxd_o not zero while rx_dv_o is low");

   // markers only on valid bytes
   assert property (@(posedge rx_clk) disable iff (reset) (sop_i || eop_i) |-> rx_dv_i)
      else $error("sop_o or eop_o without rx_dv_o");

   // done means nothing on the line
   assert property (@(posedge rx_clk) disable iff (reset) done_i |-> !rx_dv_i)
      else $error("rx_dv_o high while done_o is high");

endmodule

bind ethgen_top ethgen_checker u_chk
(
   .rx_clk  (rx_clk),
   .reset   (reset),
   .rxd_i   (rxd_o),
   .rx_dv_i (rx_dv_o),
   .sop_i   (sop_o),
   .eop_i   (eop_o),
   .done_i  (done_o)
);

`default_nettype wire

// ==== tb_ethgen.sv ====
// random descriptors from a fixed xorshift seed; each frame checked byte by byte against a model
`default_nettype none
`timescale 1ns/1ps

module tb_ethgen;

   localparam int NUM_DESC    = 40;
   localparam int MAX_FRAME   = 7 + 1 + 12 + 4 + 2 + 80 + 4;   // longest preamble..fcs
   localparam int MAX_IPG     = 12;
   localparam int CYCLE_LIMIT = NUM_DESC * (MAX_FRAME + MAX_IPG + 8) * 2 + 100;

   logic                    rx_clk = 1'b0;
   logic                    reset;
   logic                    start_i;
   ethgen_pkg::frame_desc_t desc_i;
   logic [7:0]              rxd_o;
   logic                    rx_dv_o;
   logic                    sop_o;
   logic                    eop_o;
   logic                    done_o;

   logic [31:0] rng = 32'he4e8;
   logic [7:0]  exp_q[$];           // expected line bytes, current frame
   logic [7:0]  exp_byte;
   logic        in_frame = 1'b0;
   int          mismatches = 0;
   int          failures   = 0;
   int          frames     = 0;     // eop seen on the line
   int          accepted   = 0;     // starts given while done was high
   int          cycles     = 0;
   int          gap        = 0;     // low cycles since last frame
   int          cur_ipg    = 0;
   int          last_ipg   = 0;

   always #4 rx_clk = ~rx_clk;

   ethgen_top uut
   (
      .rx_clk  (rx_clk),
      .reset   (reset),
      .start_i (start_i),
      .desc_i  (desc_i),
      .rxd_o   (rxd_o),
      .rx_dv_o (rx_dv_o),
      .sop_o   (sop_o),
      .eop_o   (eop_o),
      .done_o  (done_o)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift(rng);
      return rng;
   endfunction

   task automatic expect_val(input string name, input logic [31:0] got, input logic [31:0] want);
      assert (got == want) else
      begin
         mismatches++;
         $display("MISMATCH t=%0t %s got %0h expected %0h", $time, name, got, want);
      end
   endtask

   // ------------------------------------------------------------------
   // reference frame, reflected crc32 over dst..pad
   // ------------------------------------------------------------------
   task automatic build_frame(input ethgen_pkg::frame_desc_t d);
      logic [7:0]  body[$];
      logic [31:0] crc;
      logic [15:0] lt;
      int          n_pre;
      body = {};
      for (int i = 0; i < 6; i++)
         body.push_back(d.dst[8*i +: 8]);       // lsb first
      for (int i = 0; i < 6; i++)
         body.push_back(d.src[8*i +: 8]);
      if (d.vlan_en)
      begin
         body.push_back(8'h81);
         body.push_back(8'h00);
         body.push_back(d.vlan_ctl[15:8]);
         body.push_back(d.vlan_ctl[7:0]);
      end
      lt = (d.frmtype != 16'd0) ? d.frmtype : d.len;
      body.push_back(lt[15:8]);
      body.push_back(lt[7:0]);
      for (int i = 0; i < int'(d.len); i++)
      begin
         if (i == 0)
            body.push_back(d.cnt_start);
         else if (i == 1)
            body.push_back(d.cnt_step);
         else
            body.push_back(8'(int'(d.cnt_start) + (i - 2) * int'(d.cnt_step)));
      end
      while (d.pad_en && body.size() < 60)
         body.push_back(8'h00);                 // pad to minimum size
      crc = 32'hFFFF_FFFF;
      foreach (body[i])
      begin
         crc = crc ^ {24'h0, body[i]};
         for (int b = 0; b < 8; b++)
            crc = crc[0] ? ((crc >> 1) ^ 32'hEDB8_8320) : (crc >> 1);
      end
      crc = ~crc;
      n_pre = (d.preamble_len == 4'd0) ? 1 : int'(d.preamble_len);
      for (int i = 0; i < n_pre; i++)
         exp_q.push_back(8'h55);
      exp_q.push_back(8'hD5);
      foreach (body[i])
         exp_q.push_back(body[i]);
      for (int k = 0; k < 4; k++)
         exp_q.push_back(crc[8*k +: 8]);        // fcs, low byte first
   endtask

   // ------------------------------------------------------------------
   // line monitor, samples on the falling edge
   // ------------------------------------------------------------------
   always @(negedge rx_clk)
   begin
      if (!reset && rx_dv_o)
      begin
         if (!in_frame)
            assert (frames == 0 || gap >= last_ipg) else
            begin
               failures++;
               $display("t=%0t gap of %0d cycles is shorter than ipg_len %0d",
                        $time, gap, last_ipg);
            end
         expect_val("sop_o", sop_o, !in_frame);
         assert (exp_q.size() != 0) else
         begin
            failures++;
            $display("t=%0t byte on the line while no frame was expected", $time);
         end
         if (exp_q.size() != 0)
         begin
            exp_byte = exp_q.pop_front();
            expect_val("rxd_o", rxd_o, exp_byte);
            expect_val("eop_o", eop_o, exp_q.size() == 0);
         end
         if (eop_o)
            frames++;
         in_frame = (exp_q.size() != 0);
         if (!in_frame)
         begin
            last_ipg = cur_ipg;                 // gap rule for the next frame
            gap      = 0;
         end
      end
      else if (!reset)
         gap++;
   end

   // run limit, worst case frames plus gaps, doubled
   always @(posedge rx_clk)
   begin
      cycles++;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("timeout after %0d cycles, the DUT stopped finishing frames", cycles);
         $display("errors: %0d mismatches, %0d other, %0d of %0d frames",
                  mismatches, failures, frames, accepted);
         $display("Test failed");
         $finish;
      end
   end

   // ------------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------------
   initial
   begin
      ethgen_pkg::frame_desc_t d;
      logic [31:0]             r;
      reset   = 1'b1;
      start_i = 1'b0;
      desc_i  = '0;
      repeat (3) @(posedge rx_clk);
      @(negedge rx_clk);
      reset = 1'b0;
      @(negedge rx_clk);
      expect_val("rx_dv_o", rx_dv_o, 0);        // quiet after reset
      expect_val("sop_o", sop_o, 0);
      expect_val("eop_o", eop_o, 0);
      expect_val("rxd_o", rxd_o, 0);
      expect_val("done_o", done_o, 1);
      for (int n = 0; n < NUM_DESC; n++)
      begin
         while (!done_o)
            @(negedge rx_clk);
         r = next_rand();
         d.dst[31:0] = r;
         r = next_rand();
         d.dst[47:32] = r[15:0];
         d.src[47:32] = r[31:16];
         r = next_rand();
         d.src[31:0] = r;
         r = next_rand();
         d.vlan_ctl  = r[15:0];
         d.cnt_start = r[23:16];
         d.cnt_step  = r[31:24];
         r = next_rand();
         d.len          = 16'(r % 81);
         d.preamble_len = 4'(1 + (r >> 8) % 7);
         d.ipg_len      = 16'((r >> 12) % 13);
         d.vlan_en      = r[20];
         d.pad_en       = r[21];
         r = next_rand();
         d.frmtype = r[0] ? 16'h0000 : r[31:16];  // length half the time
         build_frame(d);
         cur_ipg = int'(d.ipg_len);
         desc_i  = d;
         start_i = 1'b1;
         accepted++;
         @(negedge rx_clk);
         start_i = 1'b0;
         desc_i  = ~d;                          // latch must hold the old one
         expect_val("done_o", done_o, 0);
         expect_val("rx_dv_o", rx_dv_o, 0);
         @(negedge rx_clk);
         expect_val("rx_dv_o", rx_dv_o, 1);     // second edge from the start
         if (n % 2 == 1)
         begin
            repeat (3) @(negedge rx_clk);
            start_i = 1'b1;                     // busy, dropped
            @(negedge rx_clk);
            start_i = 1'b0;
         end
      end
      while (!done_o)
         @(negedge rx_clk);
      repeat (4) @(negedge rx_clk);
      expect_val("frames", frames, accepted);
      assert (exp_q.size() == 0) else
      begin
         failures++;
         $display("t=%0t last frame ended early, %0d bytes never arrived", $time, exp_q.size());
      end
      $display("errors: %0d mismatches, %0d other, %0d of %0d frames",
               mismatches, failures, frames, accepted);
      if (mismatches + failures == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
ethgen_pkg.sv
frame_sequencer.sv
header_byte_mux.sv
payload_pattern.sv
crc32_gen.sv
gmii_rx_stage.sv
ethgen_top.sv
ethgen_checker.sv
tb_ethgen.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_ethgen
FILELIST  = sources.f
OBJDIR    = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: simulate clean

# build, run, and fail unless the pass line shows up
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
